// ==== dv/outputPort_vectors.txt ====
// test req lId nId eId wId sId lLen nLen eLen wLen sLen lData nData eData wData sData
// expGrant expValid expData. Hex, one line per cycle, req bit 0 is L up to bit 4 is S.
1 00 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 01 0 0000
1 00 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 01 0 0000
1 00 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 01 0 0000
2 02 0 1 0 0 0 000 003 000 000 000 1111 2222 3333 4444 5555 01 0 0000
2 02 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 1 2222
2 02 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 1 2222
2 02 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 1 2222
2 02 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 1 2222
2 02 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 1 2222
2 02 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 1 2222
2 00 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 04 0 2222
3 15 1 0 1 0 1 002 000 002 000 002 1111 2222 3333 4444 5555 01 0 0000
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 20 1 5555
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 20 1 5555
3 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 20 1 5555
4 15 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
4 14 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 0 1111
4 01 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 0 3333
4 01 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
4 01 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
4 01 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 1 1111
4 00 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 02 0 1111
5 04 0 0 1 1 0 000 000 003 005 000 1111 2222 3333 4444 5555 01 0 0000
5 0c 0 0 0 1 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
5 0c 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
5 0c 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
5 0c 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 1 3333
5 0c 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 10 1 4444
5 00 0 0 0 0 0 000 000 000 000 000 1111 2222 3333 4444 5555 08 0 3333
6 1f 1 1 1 1 1 000 000 000 000 000 0101 0202 0303 0404 0505 01 0 0000
6 1f 0 0 0 0 0 000 000 000 000 000 1a01 2b02 3c03 4d04 5e05 02 1 1a01
6 1d 0 0 0 0 0 000 000 000 000 000 1a11 2b12 3c13 4d14 5e15 04 0 2b12
6 1f 0 0 0 0 0 000 000 000 000 000 1a21 2b22 3c23 4d24 5e25 08 1 3c23
6 1f 0 0 0 0 0 000 000 000 000 000 1a31 2b32 3c33 4d34 5e35 10 1 4d34
6 1f 0 0 0 0 0 000 000 000 000 000 1a41 2b42 3c43 4d44 5e45 20 1 5e45
6 00 0 0 0 0 0 000 000 000 000 000 1a51 2b52 3c53 4d54 5e55 02 0 1a51
6 00 0 0 0 0 0 000 000 000 000 000 1a61 2b62 3c63 4d64 5e65 01 0 0000

// ==== files.f ====
+incdir+src
src/routerPkg.sv
src/packetTimer.sv
src/portArbiter.sv
src/crossbarMux.sv
src/outputPortTop.sv
dv/outputPortTb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f files.f --top-module outputPortTb -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module outputPortTb

clean:
	rm -rf obj_dir

// ==== dv/outputPortTb.sv ====
`include "router_consts.svh"

module outputPortTb
  import routerPkg::*;
();

  localparam int NUM_VECTORS = 43;
  localparam int FIELDS      = 20; // Tokens per vector line.
  localparam int CYCLE_LIMIT = NUM_VECTORS + 20;

  logic      clk;
  logic      rst;
  logic      lReq, nReq, eReq, wReq, sReq;
  flitId_t   lFlitId, nFlitId, eFlitId, wFlitId, sFlitId;
  pktLen_t   lLength, nLength, eLength, wLength, sLength;
  flitData_t lData, nData, eData, wData, sData;
  arbState_t grant;
  flitData_t outData;
  logic      outValid;

  logic [15:0] vecMem [NUM_VECTORS*FIELDS];
  int          cycleCount = 0;

  outputPortTop dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout: the vectors did not finish within %0d cycles.", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation timed out.");
    end
  end

  function automatic string testName(input int id);
    case (id)
      1: return "resetIdle";
      2: return "singleHold";
      3: return "timeoutRotation";
      4: return "earlyRelease";
      5: return "headerReload";
      6: return "crossbarData";
      default: return "unknown";
    endcase
  endfunction

  task automatic compareValue(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    if (actual !== expected)
    begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Output mismatch.");
    end
  endtask

  // Field order: test, req, five ids, five lengths, five words, grant, valid, data.
  task automatic applyRow(input int row);
    int base;
    base = row * FIELDS;
    {sReq, wReq, eReq, nReq, lReq} = vecMem[base+1][4:0]; // Bit 0 is L.
    lFlitId = vecMem[base+2][`FLIT_ID_W-1:0];
    nFlitId = vecMem[base+3][`FLIT_ID_W-1:0];
    eFlitId = vecMem[base+4][`FLIT_ID_W-1:0];
    wFlitId = vecMem[base+5][`FLIT_ID_W-1:0];
    sFlitId = vecMem[base+6][`FLIT_ID_W-1:0];
    lLength = vecMem[base+7][`LEN_W-1:0];
    nLength = vecMem[base+8][`LEN_W-1:0];
    eLength = vecMem[base+9][`LEN_W-1:0];
    wLength = vecMem[base+10][`LEN_W-1:0];
    sLength = vecMem[base+11][`LEN_W-1:0];
    lData   = vecMem[base+12];
    nData   = vecMem[base+13];
    eData   = vecMem[base+14];
    wData   = vecMem[base+15];
    sData   = vecMem[base+16];
  endtask

  task automatic checkRow(input int row);
    int        base;
    string     name;
    arbState_t expGrant;
    base     = row * FIELDS;
    expGrant = arbState_t'(vecMem[base+17][5:0]);
    name     = $sformatf("%s row %0d", testName(int'(vecMem[base])), row);
    compareValue({name, " grant (expected ", expGrant.name(), ")"},
                 32'(expGrant), 32'(grant));
    compareValue({name, " outValid"}, 32'(vecMem[base+18][0]), 32'(outValid));
    compareValue({name, " outData"}, 32'(vecMem[base+19]), 32'(outData));
  endtask

  initial
  begin
    rst = 1'b1;
    {lReq, nReq, eReq, wReq, sReq} = '0;
    {lFlitId, nFlitId, eFlitId, wFlitId, sFlitId} = '0;
    {lLength, nLength, eLength, wLength, sLength} = '0;
    {lData, nData, eData, wData, sData} = '0;
    $readmemh("dv/outputPort_vectors.txt", vecMem);
    // Every line carries a test id from 1 up, so a zero here means a short file.
    if (vecMem[(NUM_VECTORS-1)*FIELDS] === 16'h0 ||
        $isunknown(vecMem[(NUM_VECTORS-1)*FIELDS]))
    begin
      $display("Could not read all vectors from dv/outputPort_vectors.txt.");
      $display("RESULT: FAIL");
      $fatal(1, "Missing stimulus.");
    end
    repeat (4) @(posedge clk);
    for (int row = 0; row < NUM_VECTORS; row++)
    begin
      #1;
      rst = 1'b0;
      applyRow(row);
      #6; // Just before the next rising edge.
      checkRow(row);
      @(posedge clk);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== src/outputPortTop.sv ====
`include "router_consts.svh"

module outputPortTop
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      lReq,
  input  logic      nReq,
  input  logic      eReq,
  input  logic      wReq,
  input  logic      sReq,
  input  flitId_t   lFlitId,
  input  flitId_t   nFlitId,
  input  flitId_t   eFlitId,
  input  flitId_t   wFlitId,
  input  flitId_t   sFlitId,
  input  pktLen_t   lLength,
  input  pktLen_t   nLength,
  input  pktLen_t   eLength,
  input  pktLen_t   wLength,
  input  pktLen_t   sLength,
  input  flitData_t lData,
  input  flitData_t nData,
  input  flitData_t eData,
  input  flitData_t wData,
  input  flitData_t sData,
  output arbState_t grant,
  output flitData_t outData,
  output logic      outValid
);

  portArbiter arb (
    .clk (clk), .rst (rst),
    .lReq (lReq), .nReq (nReq), .eReq (eReq), .wReq (wReq), .sReq (sReq),
    .lFlitId (lFlitId), .nFlitId (nFlitId), .eFlitId (eFlitId),
    .wFlitId (wFlitId), .sFlitId (sFlitId),
    .lLength (lLength), .nLength (nLength), .eLength (eLength),
    .wLength (wLength), .sLength (sLength),
    .grant (grant)
  );

  // Data path follows the registered grant in the same cycle.
  crossbarMux xbar (
    .grant (grant),
    .lReq (lReq), .nReq (nReq), .eReq (eReq), .wReq (wReq), .sReq (sReq),
    .lData (lData), .nData (nData), .eData (eData), .wData (wData), .sData (sData),
    .outData (outData),
    .outValid (outValid)
  );

  // A valid flit only leaves while some input is granted.
  validNeedsGrant: assert property (
    @(posedge clk) disable iff (rst)
    outValid |-> (grant != ST_IDLE)
  );

endmodule

// ==== src/crossbarMux.sv ====
`include "router_consts.svh"

module crossbarMux
  import routerPkg::*;
(
  input  arbState_t grant,
  input  logic      lReq,
  input  logic      nReq,
  input  logic      eReq,
  input  logic      wReq,
  input  logic      sReq,
  input  flitData_t lData,
  input  flitData_t nData,
  input  flitData_t eData,
  input  flitData_t wData,
  input  flitData_t sData,
  output flitData_t outData,
  output logic      outValid
);

  logic      [`NUM_PORTS-1:0] reqVec;
  flitData_t                  dataArr [`NUM_PORTS];

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  assign dataArr[0] = lData;
  assign dataArr[1] = nData;
  assign dataArr[2] = eData;
  assign dataArr[3] = wData;
  assign dataArr[4] = sData;

  // AND-OR select on the one-hot grant. Idle leaves both outputs at zero.
  always_comb
  begin
    outData  = '0;
    outValid = 1'b0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i+1])
      begin
        outData  = outData | dataArr[i];
        outValid = outValid | reqVec[i];
      end
    end
  end

endmodule

// ==== src/portArbiter.sv ====
`include "router_consts.svh"

module portArbiter
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      lReq,
  input  logic      nReq,
  input  logic      eReq,
  input  logic      wReq,
  input  logic      sReq,
  input  flitId_t   lFlitId,
  input  flitId_t   nFlitId,
  input  flitId_t   eFlitId,
  input  flitId_t   wFlitId,
  input  flitId_t   sFlitId,
  input  pktLen_t   lLength,
  input  pktLen_t   nLength,
  input  pktLen_t   eLength,
  input  pktLen_t   wLength,
  input  pktLen_t   sLength,
  output arbState_t grant
);

  // Index 0..4 is L, N, E, W, S, which is also the rotating order.
  logic    [`NUM_PORTS-1:0] reqVec;
  logic    [`NUM_PORTS-1:0] runVec;
  logic    [`NUM_PORTS-1:0] timesUpVec;
  flitId_t                  flitIdArr [`NUM_PORTS];
  pktLen_t                  lengthArr [`NUM_PORTS];
  arbState_t                nextState;

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  assign flitIdArr[0] = lFlitId;
  assign flitIdArr[1] = nFlitId;
  assign flitIdArr[2] = eFlitId;
  assign flitIdArr[3] = wFlitId;
  assign flitIdArr[4] = sFlitId;

  assign lengthArr[0] = lLength;
  assign lengthArr[1] = nLength;
  assign lengthArr[2] = eLength;
  assign lengthArr[3] = wLength;
  assign lengthArr[4] = sLength;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : timerGen
    packetTimer pktTimer (
      .clk     (clk),
      .rst     (rst),
      .flitId  (flitIdArr[i]),
      .length  (lengthArr[i]),
      .run     (runVec[i]),
      .timesUp (timesUpVec[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= ST_IDLE;
    else
      grant <= nextState;
  end

  always_comb
  begin : nextStateLogic
    int   holderIdx;
    int   startIdx;
    int   idx;
    logic found;
    holderIdx = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i+1])
        holderIdx = i;
    end
    // Search starts just after the holder, so the holder itself comes last.
    startIdx  = (grant == ST_IDLE) ? 0 : (holderIdx + 1) % `NUM_PORTS;
    nextState = ST_IDLE;
    runVec    = '0;
    found     = 1'b0;
    idx       = 0;
    if (grant != ST_IDLE && reqVec[holderIdx] && !timesUpVec[holderIdx])
    begin
      nextState         = grant; // Holder keeps the port.
      runVec[holderIdx] = 1'b1;
    end
    else
    begin
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        idx = (startIdx + k) % `NUM_PORTS;
        if (!found && reqVec[idx])
        begin
          found     = 1'b1;
          nextState = arbState_t'(6'(1) << (idx + 1));
        end
      end
    end
  end

  grantLegal: assert property (
    @(posedge clk) disable iff (rst)
    grant inside {ST_IDLE, ST_L, ST_N, ST_E, ST_W, ST_S}
  );

  // Only the holder's timer may count.
  singleRun: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(runVec) && ((runVec & ~grant[`NUM_PORTS:1]) == '0)
  );

endmodule

// ==== src/packetTimer.sv ====
`include "router_consts.svh"

module packetTimer
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitId_t flitId,
  input  pktLen_t length,
  input  logic    run,
  output logic    timesUp
);

  pktLen_t limit; // Hold limit of the current packet.
  pktLen_t count; // Cycles spent granted so far.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // A header reloads the limit even while another input holds the port.
      if (flitId == flitId_t'(`HEAD_ID))
        limit <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0; // Restart on every new grant.
    end
  end

  assign timesUp = (count == limit);

  // The arbiter drops run as soon as the count reaches the limit.
  runWithinLimit: assert property (
    @(posedge clk) disable iff (rst)
    run |-> (count <= limit)
  );

endmodule

// ==== src/routerPkg.sv ====
`include "router_consts.svh"

package routerPkg;

  typedef logic [`FLIT_ID_W-1:0] flitId_t;

  // Also used for the timer count.
  typedef logic [`LEN_W-1:0] pktLen_t;

  typedef logic [`FLIT_W-1:0] flitData_t;

  // One-hot arbiter state. Bit n+1 is the grant to input n.
  typedef enum logic [5:0]
  {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbState_t;

endpackage

// ==== src/router_consts.svh ====
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// Inputs competing for one output: Local, North, East, West, South.
`define NUM_PORTS 5

// Flit id field width.
`define FLIT_ID_W 3

// Packet length and hold timer width.
`define LEN_W 12

// Payload word carried by each flit.
`define FLIT_W 16

// Flit id code of a header flit.
`define HEAD_ID 1

`endif
